// File: src/ram_tile_defines.svh
`ifndef RAM_TILE_DEFINES_SVH
`define RAM_TILE_DEFINES_SVH

// Geometry of the register-file tile
`define RAM_DEPTH 12
`define RAM_DATA_WIDTH 32

// A row is split into bytes that can be written one by one
`define RAM_WORD_WIDTH 8
`define RAM_NUM_WORDS 4

// Four bits cover the twelve entries and leave the codes 12 to 15 illegal
`define RAM_ADDR_WIDTH 4

// Port counts
`define RAM_NUM_WR_PORTS 2
`define RAM_NUM_RD_PORTS 2

`endif

// File: src/ram_tile_pkg.sv
`default_nettype none

`include "ram_tile_defines.svh"

package ram_tile_pkg;

  // --------------------
  // Vector types
  // --------------------

  // Index of one entry
  typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // One full row of the tile
  typedef logic [`RAM_DATA_WIDTH-1:0] ram_data_t;

  // One byte lane of a row
  typedef logic [`RAM_WORD_WIDTH-1:0] ram_word_t;

  // Per-byte enables of a write, also used as a forwarding mask
  typedef logic [`RAM_NUM_WORDS-1:0] ram_word_en_t;

  // One bit per write port
  typedef logic [`RAM_NUM_WR_PORTS-1:0] ram_wr_mask_t;

endpackage

`default_nettype wire

// File: src/ram_storage.sv
`default_nettype none

`include "ram_tile_defines.svh"

module ram_storage (
  input  logic                                                 wr_clk,
  input  logic                                                 wr_rst,
  input  ram_tile_pkg::ram_wr_mask_t                           wr_valid,
  input  ram_tile_pkg::ram_addr_t    [`RAM_NUM_WR_PORTS-1:0]   wr_addr,
  input  ram_tile_pkg::ram_data_t    [`RAM_NUM_WR_PORTS-1:0]   wr_data,
  input  ram_tile_pkg::ram_word_en_t [`RAM_NUM_WR_PORTS-1:0]   wr_word_en,
  input  ram_tile_pkg::ram_addr_t    [`RAM_NUM_RD_PORTS-1:0]   rd_addr,
  output ram_tile_pkg::ram_data_t    [`RAM_NUM_RD_PORTS-1:0]   stored_data
);

  import ram_tile_pkg::*;

  // The entry array itself
  ram_data_t mem [`RAM_DEPTH];

  // Write data and byte enables after steering to each entry
  ram_data_t    row_data [`RAM_DEPTH];
  ram_word_en_t row_en   [`RAM_DEPTH];

  // --------------------
  // Write decode
  // --------------------

  // Ports never share an address in one cycle, so an OR of the hitting ports
  // yields the data of the single port that targets the entry
  always_comb begin
    for (int e = 0; e < `RAM_DEPTH; e++) begin
      row_data[e] = '0;
      row_en[e] = '0;
      for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
        if (wr_valid[p] && (wr_addr[p] == ram_addr_t'(e))) begin
          row_data[e] = row_data[e] | wr_data[p];
          row_en[e] = row_en[e] | wr_word_en[p];
        end
      end
    end
  end

  // --------------------
  // Entry flops
  // --------------------

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      for (int e = 0; e < `RAM_DEPTH; e++) begin
        mem[e] <= '0;
      end
    end else begin
      for (int e = 0; e < `RAM_DEPTH; e++) begin
        for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
          // Only the enabled bytes of a row take the new value
          if (row_en[e][w]) begin
            mem[e][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] <=
                row_data[e][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
          end
        end
      end
    end
  end

  // --------------------
  // Read ports
  // --------------------

  for (genvar r = 0; r < `RAM_NUM_RD_PORTS; r++) begin : gen_rd_port
    assign stored_data[r] = mem[rd_addr[r]];
  end

  // Writes outside the array would be silently dropped by the decode
  for (genvar p = 0; p < `RAM_NUM_WR_PORTS; p++) begin : gen_wr_range_chk
    wr_addr_in_range_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
        wr_valid[p] |-> (wr_addr[p] < ram_addr_t'(`RAM_DEPTH)));
  end

  // Two ports on one entry would merge their data in the OR above
  for (genvar a = 0; a < `RAM_NUM_WR_PORTS - 1; a++) begin : gen_conflict_a
    for (genvar b = a + 1; b < `RAM_NUM_WR_PORTS; b++) begin : gen_conflict_b
      no_wr_conflict_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
          (wr_valid[a] && wr_valid[b]) |-> (wr_addr[a] != wr_addr[b]));
    end
  end

endmodule

`default_nettype wire

// File: src/ram_bypass_select.sv
`default_nettype none

`include "ram_tile_defines.svh"

module ram_bypass_select (
  input  ram_tile_pkg::ram_wr_mask_t                           wr_valid,
  input  ram_tile_pkg::ram_addr_t    [`RAM_NUM_WR_PORTS-1:0]   wr_addr,
  input  ram_tile_pkg::ram_data_t    [`RAM_NUM_WR_PORTS-1:0]   wr_data,
  input  ram_tile_pkg::ram_word_en_t [`RAM_NUM_WR_PORTS-1:0]   wr_word_en,
  input  ram_tile_pkg::ram_addr_t                              rd_addr,
  output ram_tile_pkg::ram_data_t                              fwd_data,
  output ram_tile_pkg::ram_word_en_t                           fwd_mask
);

  import ram_tile_pkg::*;

  // Write ports that target the address being read this cycle
  ram_wr_mask_t wr_match;

  // --------------------
  // Address compare
  // --------------------

  for (genvar p = 0; p < `RAM_NUM_WR_PORTS; p++) begin : gen_match
    assign wr_match[p] = wr_valid[p] && (wr_addr[p] == rd_addr);
  end

  // --------------------
  // Forward select
  // --------------------

  // With no match the mask stays zero and the stored row passes unchanged
  always_comb begin
    fwd_data = '0;
    fwd_mask = '0;
    for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
      if (wr_match[p]) begin
        fwd_data = wr_data[p];
        fwd_mask = wr_word_en[p];
      end
    end
  end

  // Relies on the write-port conflict rule enforced at the storage
  always_comb begin
    single_match_a: assert final ($onehot0(wr_match));
  end

endmodule

`default_nettype wire

// File: src/ram_word_merge.sv
`default_nettype none

`include "ram_tile_defines.svh"

module ram_word_merge (
  input  ram_tile_pkg::ram_data_t    stored_data,
  input  ram_tile_pkg::ram_data_t    fwd_data,
  input  ram_tile_pkg::ram_word_en_t fwd_mask,
  output ram_tile_pkg::ram_data_t    rd_data
);

  import ram_tile_pkg::*;

  // --------------------
  // Byte lanes
  // --------------------

  for (genvar w = 0; w < `RAM_NUM_WORDS; w++) begin : gen_byte
    ram_word_t stored_byte;
    ram_word_t fwd_byte;

    assign stored_byte = stored_data[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
    assign fwd_byte = fwd_data[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];

    // A set mask bit means this byte is being written in the same cycle
    assign rd_data[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
        fwd_mask[w] ? fwd_byte : stored_byte;
  end

endmodule

`default_nettype wire

// File: src/ram_flops_tile.sv
`default_nettype none

`include "ram_tile_defines.svh"

module ram_flops_tile (
  input  logic                                                 wr_clk,
  input  logic                                                 wr_rst,
  input  ram_tile_pkg::ram_wr_mask_t                           wr_valid,
  input  ram_tile_pkg::ram_addr_t    [`RAM_NUM_WR_PORTS-1:0]   wr_addr,
  input  ram_tile_pkg::ram_data_t    [`RAM_NUM_WR_PORTS-1:0]   wr_data,
  input  ram_tile_pkg::ram_word_en_t [`RAM_NUM_WR_PORTS-1:0]   wr_word_en,
  input  logic                       [`RAM_NUM_RD_PORTS-1:0]   rd_addr_valid,
  input  ram_tile_pkg::ram_addr_t    [`RAM_NUM_RD_PORTS-1:0]   rd_addr,
  output logic                       [`RAM_NUM_RD_PORTS-1:0]   rd_data_valid,
  output ram_tile_pkg::ram_data_t    [`RAM_NUM_RD_PORTS-1:0]   rd_data
);

  import ram_tile_pkg::*;

  // Rows as held in the flops, before any forwarding
  ram_data_t    [`RAM_NUM_RD_PORTS-1:0] stored_data;

  // Same-cycle write data and its byte mask, per read port
  ram_data_t    [`RAM_NUM_RD_PORTS-1:0] fwd_data;
  ram_word_en_t [`RAM_NUM_RD_PORTS-1:0] fwd_mask;

  // --------------------
  // Storage
  // --------------------

  ram_storage u_storage (
    .wr_clk      (wr_clk),
    .wr_rst      (wr_rst),
    .wr_valid    (wr_valid),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_word_en  (wr_word_en),
    .rd_addr     (rd_addr),
    .stored_data (stored_data)
  );

  // --------------------
  // Read paths
  // --------------------

  for (genvar r = 0; r < `RAM_NUM_RD_PORTS; r++) begin : gen_rd_path
    ram_bypass_select u_bypass (
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_word_en (wr_word_en),
      .rd_addr    (rd_addr[r]),
      .fwd_data   (fwd_data[r]),
      .fwd_mask   (fwd_mask[r])
    );

    ram_word_merge u_merge (
      .stored_data (stored_data[r]),
      .fwd_data    (fwd_data[r]),
      .fwd_mask    (fwd_mask[r]),
      .rd_data     (rd_data[r])
    );

    // The storage read mux has no entries behind codes 12 to 15
    rd_addr_in_range_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
        rd_addr_valid[r] |-> (rd_addr[r] < ram_addr_t'(`RAM_DEPTH)));
  end

  // Reads complete in the cycle they are requested
  assign rd_data_valid = rd_addr_valid;

endmodule

`default_nettype wire

// File: verif/ram_tile_model.svh
`ifndef RAM_TILE_MODEL_SVH
`define RAM_TILE_MODEL_SVH

// Expected contents of every entry, kept in step with the DUT
ram_data_t model_mem [`RAM_DEPTH];

// Applies the writes seen at one rising edge
task automatic update_model();
  if (wr_rst) begin
    for (int e = 0; e < `RAM_DEPTH; e++) begin
      model_mem[e] = '0;
    end
  end else begin
    for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
      if (wr_valid[p]) begin
        for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
          if (wr_word_en[p][w]) begin
            model_mem[wr_addr[p]][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
                wr_data[p][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
          end
        end
      end
    end
  end
endtask

// Row a read of addr returns in this cycle, with same-cycle writes forwarded
function automatic ram_data_t expected_row(input ram_addr_t addr);
  ram_data_t row;
  row = model_mem[addr];
  for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
    if (wr_valid[p] && (wr_addr[p] == addr)) begin
      for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
        if (wr_word_en[p][w]) begin
          row[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
              wr_data[p][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
        end
      end
    end
  end
  return row;
endfunction

`endif

// File: verif/ram_tile_tb.sv
`default_nettype none

`include "ram_tile_defines.svh"

module ram_tile_tb;

  import ram_tile_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY = 1;
  localparam int DIRECTED_CYCLES = 24;
  localparam int RANDOM_CYCLES = 1000;
  localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
                                   `RAM_DEPTH + 20;
  localparam logic [31:0] LFSR_SEED = 32'd82657;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                                 wr_clk;
  logic                                 wr_rst;
  ram_wr_mask_t                         wr_valid;
  ram_addr_t    [`RAM_NUM_WR_PORTS-1:0] wr_addr;
  ram_data_t    [`RAM_NUM_WR_PORTS-1:0] wr_data;
  ram_word_en_t [`RAM_NUM_WR_PORTS-1:0] wr_word_en;
  logic         [`RAM_NUM_RD_PORTS-1:0] rd_addr_valid;
  ram_addr_t    [`RAM_NUM_RD_PORTS-1:0] rd_addr;
  logic         [`RAM_NUM_RD_PORTS-1:0] rd_data_valid;
  ram_data_t    [`RAM_NUM_RD_PORTS-1:0] rd_data;

  logic [31:0] lfsr_state = LFSR_SEED;
  int data_errors = 0;
  int valid_errors = 0;

  `include "ram_tile_model.svh"

  ram_flops_tile UUT (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  initial wr_clk = 1'b0;
  always #(CLK_PERIOD / 2) wr_clk = ~wr_clk;

  // --------------------
  // Random numbers
  // --------------------

  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  // Legal entry addresses only
  function automatic ram_addr_t pick_addr();
    return ram_addr_t'(draw_bits(`RAM_ADDR_WIDTH) % `RAM_DEPTH);
  endfunction

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic next_cycle();
    @(posedge wr_clk);
    #DRIVE_DELAY;
  endtask

  task automatic drive_idle();
    wr_valid = '0;
    wr_addr = '0;
    wr_data = '0;
    wr_word_en = '0;
    rd_addr_valid = '0;
    rd_addr = '0;
  endtask

  task automatic apply_reset();
    wr_rst = 1'b1;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge wr_clk);
    #DRIVE_DELAY;
    wr_rst = 1'b0;
  endtask

  task automatic set_write(input int port, input ram_addr_t addr, input ram_data_t data,
                           input ram_word_en_t en);
    wr_valid[port] = 1'b1;
    wr_addr[port] = addr;
    wr_data[port] = data;
    wr_word_en[port] = en;
  endtask

  task automatic set_read(input int port, input ram_addr_t addr);
    rd_addr_valid[port] = 1'b1;
    rd_addr[port] = addr;
  endtask

  // Every entry once on each port, port 1 walking down from the top
  task automatic read_all_entries();
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      drive_idle();
      set_read(0, ram_addr_t'(a));
      set_read(1, ram_addr_t'(`RAM_DEPTH - 1 - a));
      next_cycle();
    end
  endtask

  task automatic drive_random();
    for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
      wr_valid[p] = lfsr_step();
      wr_addr[p] = pick_addr();
      wr_data[p] = draw_bits(`RAM_DATA_WIDTH);
      wr_word_en[p] = ram_word_en_t'(draw_bits(`RAM_NUM_WORDS));
    end
    // Both ports on one entry is illegal, so the second one backs off
    if (wr_valid[0] && wr_valid[1] && (wr_addr[0] == wr_addr[1])) begin
      wr_valid[1] = 1'b0;
    end
    for (int r = 0; r < `RAM_NUM_RD_PORTS; r++) begin
      rd_addr_valid[r] = lfsr_step();
      // About half the reads aim at a write address to exercise the bypass
      if (lfsr_step()) begin
        rd_addr[r] = wr_addr[lfsr_step()];
      end else begin
        rd_addr[r] = pick_addr();
      end
    end
  endtask

  // --------------------
  // Model and checks
  // --------------------

  always @(posedge wr_clk) begin
    update_model();
  end

  // Outputs are combinational and settled by the falling edge
  always @(negedge wr_clk) begin
    ram_data_t exp_row;
    if (!wr_rst) begin
      assert (rd_data_valid === rd_addr_valid) else begin
        valid_errors++;
        $display("Fail at %0t: rd_data_valid is %b, expected %b",
                 $time, rd_data_valid, rd_addr_valid);
      end
      for (int r = 0; r < `RAM_NUM_RD_PORTS; r++) begin
        if (rd_addr_valid[r]) begin
          exp_row = expected_row(rd_addr[r]);
          assert (rd_data[r] === exp_row) else begin
            data_errors++;
            $display("Fail at %0t: rd_data[%0d] is %h, expected %h",
                     $time, r, rd_data[r], exp_row);
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the test did not reach its end after %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    apply_reset();

    // Every entry reads zero after reset, on both ports
    read_all_entries();

    // Full write, then read back
    drive_idle();
    set_write(0, 4'd3, 32'hA5C3_1E77, 4'hF);
    next_cycle();
    drive_idle();
    set_read(0, 4'd3);
    next_cycle();

    // Partial write keeps the bytes whose enables are low
    drive_idle();
    set_write(1, 4'd3, 32'h1122_3344, 4'b0101);
    next_cycle();
    drive_idle();
    set_read(0, 4'd3);
    set_read(1, 4'd3);
    next_cycle();

    // Same-cycle read of an entry being written takes the bypass
    drive_idle();
    set_write(0, 4'd5, 32'h0F0F_0F0F, 4'hF);
    next_cycle();
    drive_idle();
    set_write(1, 4'd5, 32'hDEAD_BEEF, 4'b1010);
    set_read(0, 4'd5);
    set_read(1, 4'd5);
    next_cycle();
    drive_idle();
    set_read(0, 4'd5);
    next_cycle();

    // Two writes in one cycle, then both ports read
    drive_idle();
    set_write(0, 4'd7, 32'h1357_9BDF, 4'hF);
    set_write(1, 4'd9, 32'h2468_ACE0, 4'hF);
    next_cycle();
    drive_idle();
    set_read(0, 4'd7);
    set_read(1, 4'd9);
    next_cycle();

    repeat (RANDOM_CYCLES) begin
      drive_random();
      next_cycle();
    end

    // A second reset has to clear the rows left behind by the random traffic
    apply_reset();
    read_all_entries();
    drive_idle();
    next_cycle();

    $display("Errors: %0d on rd_data, %0d on rd_data_valid", data_errors, valid_errors);
    if ((data_errors == 0) && (valid_errors == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
+incdir+verif
src/ram_tile_pkg.sv
src/ram_storage.sv
src/ram_bypass_select.sv
src/ram_word_merge.sv
src/ram_flops_tile.sv
verif/ram_tile_tb.sv

// File: Makefile
# Verilator build and run of the register-file tile

SIM       ?= verilator
TOP       ?= ram_tile_tb
RTL_TOP   ?= ram_flops_tile
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log is searched for the fail message, a crash also counts as a failure
run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(SIM) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
